/* common/dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

    // ------------------------------
    // uart and probe sizes
    // ------------------------------
    localparam int CLKS_PER_BIT    = 16;
    localparam int CLK_CNT_W       = $clog2(CLKS_PER_BIT);
    localparam int BYTE_W          = 8;
    localparam int PROBE_W         = 32;
    localparam int FLAG_W          = 8;

    // dump layout: flags, pc lsb first, ir lsb first
    localparam int SNAP_BYTES      = 9;
    localparam int SNAP_IDX_W      = 4;
    localparam int RST_HOLD_CYCLES = 16;
    localparam int HOLD_CNT_W      = $clog2(RST_HOLD_CYCLES + 1);
    localparam int REPLY_BYTES     = 4;  // class, action, cr, lf

    typedef logic [BYTE_W-1:0] byte_t;

    // ------------------------------
    // host command letters
    // ------------------------------
    localparam byte_t CMD_RESET      = 8'h72;  // r
    localparam byte_t CMD_RISE       = 8'h7a;  // z
    localparam byte_t CMD_FALL       = 8'h78;  // x
    localparam byte_t CMD_PULSE      = 8'h63;  // c
    localparam byte_t CMD_RST_TOGGLE = 8'h65;  // e
    localparam byte_t CMD_STATUS     = 8'h73;  // s

    // reply characters
    localparam byte_t ACK_R      = 8'h52;  // R, reset class
    localparam byte_t ACK_C      = 8'h43;  // C, clock class
    localparam byte_t ACK_O      = 8'h4f;  // O, other
    localparam byte_t ACK_S      = 8'h73;  // s
    localparam byte_t ACK_RISE   = 8'h72;  // r
    localparam byte_t ACK_FALL   = 8'h66;  // f
    localparam byte_t ACK_PULSE  = 8'h74;  // t
    localparam byte_t ACK_TOGGLE = 8'h61;  // a
    localparam byte_t ACK_OK     = 8'h6b;  // k
    localparam byte_t CHAR_CR    = 8'h0d;
    localparam byte_t CHAR_LF    = 8'h0a;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RST_HOLD,
        ST_STEP,
        ST_REPLY_SEND,
        ST_REPLY_WAIT,
        ST_DUMP_SEND,
        ST_DUMP_WAIT
    } cmd_state_e;

endpackage

`default_nettype wire

/* uart/uart_rx.sv */
`default_nettype none

module uart_rx (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           rx_i,
    output logic           rx_valid_o,
    output dbg_pkg::byte_t rx_byte_o
);
    import dbg_pkg::*;

    logic                 rx_meta;
    logic                 rx_sync;
    logic                 busy;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic                 half_bit;
    logic                 full_bit;
    byte_t                shift_q;

    // line into the clk domain, idles high
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    assign half_bit = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign full_bit = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

    // ------------------------------
    // bit timing
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy       <= 1'b0;
            clk_cnt    <= '0;
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (!busy) begin
                clk_cnt <= '0;
                bit_cnt <= '0;
                if (!rx_sync) begin
                    busy <= 1'b1;              // start edge seen
                end
            end else if (bit_cnt == 4'd0) begin
                if (half_bit) begin
                    clk_cnt <= '0;
                    if (rx_sync) begin
                        busy <= 1'b0;          // glitch, not a start bit
                    end else begin
                        bit_cnt <= 4'd1;
                    end
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
            end else if (full_bit) begin
                clk_cnt <= '0;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd9) begin
                    busy       <= 1'b0;
                    rx_valid_o <= rx_sync;     // low stop bit drops the byte
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (busy && full_bit && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8)) begin
            shift_q <= {rx_sync, shift_q[BYTE_W-1:1]};
        end
    end

    assign rx_byte_o = shift_q;

    a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        rx_valid_o |=> !rx_valid_o);

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`default_nettype none

module uart_tx (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           tx_start_i,
    input  dbg_pkg::byte_t tx_byte_i,
    output logic           tx_o,
    output logic           tx_busy_o,
    output logic           tx_done_o
);
    import dbg_pkg::*;

    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;   // bit now on the line
    logic                 bit_end;
    byte_t                shift_q;

    assign bit_end = tx_busy_o && (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_o      <= 1'b1;
            tx_busy_o <= 1'b0;
            tx_done_o <= 1'b0;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
        end else begin
            tx_done_o <= 1'b0;
            if (!tx_busy_o) begin
                if (tx_start_i) begin
                    tx_busy_o <= 1'b1;
                    clk_cnt   <= '0;
                    bit_cnt   <= '0;
                    tx_o      <= 1'b0;         // start bit
                end
            end else if (bit_end) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    tx_busy_o <= 1'b0;         // end of stop bit
                    tx_done_o <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    tx_o    <= (bit_cnt == 4'd8) ? 1'b1 : shift_q[0];
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // payload, lsb goes out first
    always_ff @(posedge clk) begin
        if (!tx_busy_o && tx_start_i) begin
            shift_q <= tx_byte_i;
        end else if (bit_end && (bit_cnt < 4'd8)) begin
            shift_q <= {1'b1, shift_q[BYTE_W-1:1]};
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_start_i |-> !tx_busy_o);

endmodule

`default_nettype wire

/* rtl/status_snapshot.sv */
`default_nettype none

module status_snapshot (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           capture_i,
    input  logic [dbg_pkg::PROBE_W-1:0]    pc_i,
    input  logic [dbg_pkg::PROBE_W-1:0]    ir_i,
    input  logic [dbg_pkg::FLAG_W-1:0]     flags_i,
    input  logic [dbg_pkg::SNAP_IDX_W-1:0] idx_i,
    output dbg_pkg::byte_t                 byte_o
);
    import dbg_pkg::*;

    logic [PROBE_W-1:0] pc_q;
    logic [PROBE_W-1:0] ir_q;
    logic [FLAG_W-1:0]  flags_q;
    byte_t              snap_words [SNAP_BYTES];

    // frozen copy, target may keep running during a dump
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q    <= '0;
            ir_q    <= '0;
            flags_q <= '0;
        end else if (capture_i) begin
            pc_q    <= pc_i;
            ir_q    <= ir_i;
            flags_q <= flags_i;
        end
    end

    // ------------------------------
    // byte layout of the dump
    // ------------------------------
    always_comb begin
        snap_words[0] = flags_q;
        for (int i = 0; i < PROBE_W / BYTE_W; i++) begin
            snap_words[1 + i]                    = pc_q[i*BYTE_W +: BYTE_W];
            snap_words[1 + PROBE_W / BYTE_W + i] = ir_q[i*BYTE_W +: BYTE_W];
        end
    end

    assign byte_o = (idx_i < SNAP_IDX_W'(SNAP_BYTES)) ? snap_words[idx_i] : '0;

    // sequencer must never walk past the last dump byte
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        idx_i < SNAP_IDX_W'(SNAP_BYTES));

endmodule

`default_nettype wire

/* rtl/cmd_sequencer.sv */
`default_nettype none

module cmd_sequencer (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           rx_valid_i,
    input  dbg_pkg::byte_t                 rx_byte_i,
    input  logic                           tx_busy_i,
    input  logic                           tx_done_i,
    input  dbg_pkg::byte_t                 snap_byte_i,
    output logic                           tx_start_o,
    output dbg_pkg::byte_t                 tx_byte_o,
    output logic                           snap_capture_o,
    output logic [dbg_pkg::SNAP_IDX_W-1:0] snap_idx_o,
    output logic                           target_clk_o,
    output logic                           target_rst_n_o
);
    import dbg_pkg::*;

    cmd_state_e            state_q;
    byte_t                 cmd_q;      // command being answered
    logic [HOLD_CNT_W-1:0] hold_cnt;
    logic [SNAP_IDX_W-1:0] byte_idx;   // reply or dump position
    logic                  cmd_accept;
    logic                  last_reply;
    logic                  last_dump;
    byte_t                 class_char;
    byte_t                 act_char;
    byte_t                 reply_byte;

    assign cmd_accept     = (state_q == ST_IDLE) && rx_valid_i;
    assign last_reply     = (byte_idx == SNAP_IDX_W'(REPLY_BYTES - 1));
    assign last_dump      = (byte_idx == SNAP_IDX_W'(SNAP_BYTES - 1));
    assign snap_capture_o = cmd_accept && (rx_byte_i == CMD_STATUS);

    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            cmd_q <= rx_byte_i;
        end
    end

    // ------------------------------
    // control FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= ST_IDLE;
            hold_cnt       <= '0;
            byte_idx       <= '0;
            target_clk_o   <= 1'b0;
            target_rst_n_o <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    hold_cnt <= '0;
                    byte_idx <= '0;
                    if (rx_valid_i) begin
                        state_q <= ST_REPLY_SEND;
                        case (rx_byte_i)
                            CMD_RESET: begin
                                target_rst_n_o <= 1'b0;
                                state_q        <= ST_RST_HOLD;
                            end
                            CMD_RISE:       target_clk_o   <= 1'b1;
                            CMD_FALL:       target_clk_o   <= 1'b0;
                            CMD_RST_TOGGLE: target_rst_n_o <= ~target_rst_n_o;
                            CMD_PULSE: begin
                                target_clk_o <= 1'b1;   // falls in ST_STEP
                                state_q      <= ST_STEP;
                            end
                            CMD_STATUS:     state_q        <= ST_DUMP_SEND;
                            default:        state_q        <= ST_REPLY_SEND;
                        endcase
                    end
                end
                ST_RST_HOLD: begin
                    if (hold_cnt == HOLD_CNT_W'(RST_HOLD_CYCLES)) begin
                        target_rst_n_o <= 1'b1;
                        state_q        <= ST_REPLY_SEND;
                    end else begin
                        target_clk_o <= ~target_clk_o;
                        hold_cnt     <= hold_cnt + 1'b1;
                    end
                end
                ST_STEP: begin
                    target_clk_o <= 1'b0;
                    state_q      <= ST_REPLY_SEND;
                end
                ST_REPLY_SEND: if (!tx_busy_i) state_q <= ST_REPLY_WAIT;
                ST_REPLY_WAIT: begin
                    if (tx_done_i) begin
                        byte_idx <= byte_idx + 1'b1;
                        state_q  <= last_reply ? ST_IDLE : ST_REPLY_SEND;
                    end
                end
                ST_DUMP_SEND: if (!tx_busy_i) state_q <= ST_DUMP_WAIT;
                ST_DUMP_WAIT: begin
                    if (tx_done_i) begin
                        byte_idx <= last_dump ? '0 : byte_idx + 1'b1;  // stays in dump range
                        state_q  <= last_dump ? ST_IDLE : ST_DUMP_SEND;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // reply letters per command
    always_comb begin
        case (cmd_q)
            CMD_RESET, CMD_RST_TOGGLE:     class_char = ACK_R;
            CMD_RISE, CMD_FALL, CMD_PULSE: class_char = ACK_C;
            default:                       class_char = ACK_O;
        endcase
        case (cmd_q)
            CMD_RESET:      act_char = ACK_S;
            CMD_RISE:       act_char = ACK_RISE;
            CMD_FALL:       act_char = ACK_FALL;
            CMD_PULSE:      act_char = ACK_PULSE;
            CMD_RST_TOGGLE: act_char = ACK_TOGGLE;
            default:        act_char = ACK_OK;
        endcase
    end

    assign reply_byte = (byte_idx == '0)                 ? class_char :
                        (byte_idx == SNAP_IDX_W'(1))     ? act_char   :
                        (byte_idx == SNAP_IDX_W'(2))     ? CHAR_CR    : CHAR_LF;

    assign tx_start_o = ((state_q == ST_REPLY_SEND) || (state_q == ST_DUMP_SEND)) && !tx_busy_i;
    assign tx_byte_o  = (state_q == ST_DUMP_SEND) ? snap_byte_i : reply_byte;
    assign snap_idx_o = byte_idx;

    // transmitter picks up every start
    a_start_rule: assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_start_o |=> tx_busy_i);

endmodule

`default_nettype wire

/* rtl/debug_top.sv */
`default_nettype none

module debug_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        rx_i,
    output logic                        tx_o,
    input  logic [dbg_pkg::PROBE_W-1:0] pc_i,
    input  logic [dbg_pkg::PROBE_W-1:0] ir_i,
    input  logic [dbg_pkg::FLAG_W-1:0]  flags_i,
    output logic                        target_clk_o,
    output logic                        target_rst_n_o
);
    import dbg_pkg::*;

    logic                  rx_valid;
    byte_t                 rx_byte;
    logic                  tx_start;
    byte_t                 tx_byte;
    logic                  tx_busy;
    logic                  tx_done;
    logic                  snap_capture;
    logic [SNAP_IDX_W-1:0] snap_idx;
    byte_t                 snap_byte;

    // ------------------------------
    // host link
    // ------------------------------
    uart_rx u_uart_rx (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rx_i       (rx_i),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_o       (tx_o),
        .tx_busy_o  (tx_busy),
        .tx_done_o  (tx_done)
    );

    cmd_sequencer u_cmd_sequencer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rx_valid_i     (rx_valid),
        .rx_byte_i      (rx_byte),
        .tx_busy_i      (tx_busy),
        .tx_done_i      (tx_done),
        .snap_byte_i    (snap_byte),
        .tx_start_o     (tx_start),
        .tx_byte_o      (tx_byte),
        .snap_capture_o (snap_capture),
        .snap_idx_o     (snap_idx),
        .target_clk_o   (target_clk_o),
        .target_rst_n_o (target_rst_n_o)
    );

    status_snapshot u_status_snapshot (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .capture_i (snap_capture),
        .pc_i      (pc_i),
        .ir_i      (ir_i),
        .flags_i   (flags_i),
        .idx_i     (snap_idx),
        .byte_o    (snap_byte)
    );

endmodule

`default_nettype wire

/* dv/tb_debug_top.sv */
`default_nettype none

module tb_debug_top;
    import dbg_pkg::*;

    localparam int NUM_TESTS   = 14;
    localparam int RST_CYCLES  = 16;
    localparam int FRAME_CYC   = 10 * CLKS_PER_BIT;
    localparam int IDLE_CYCLES = 4 * FRAME_CYC;
    localparam int FRAME_WAIT  = 3 * FRAME_CYC;   // max gap before a reply frame starts
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (1 + SNAP_BYTES) * FRAME_CYC * 2
                                  + RST_CYCLES + IDLE_CYCLES;

    logic               clk;
    logic               rst_n_i;
    logic               rx_i;
    logic               tx_o;
    logic [PROBE_W-1:0] pc_i;
    logic [PROBE_W-1:0] ir_i;
    logic [FLAG_W-1:0]  flags_i;
    logic               target_clk_o;
    logic               target_rst_n_o;

    // stimulus table, one row per command
    byte_t       tbl_cmd   [NUM_TESTS];
    logic [15:0] tbl_ack   [NUM_TESTS];   // class and action letters
    logic        tbl_snap  [NUM_TESTS];
    int          tbl_len   [NUM_TESTS];
    logic        tbl_clk   [NUM_TESTS];
    logic        tbl_rst   [NUM_TESTS];
    int          tbl_edges [NUM_TESTS];   // target clock edges while reset low

    logic [31:0]        lcg_state = 32'h7eda1702;
    logic [PROBE_W-1:0] pc_val;
    logic [PROBE_W-1:0] ir_val;
    logic [FLAG_W-1:0]  flags_val;
    logic [PROBE_W-1:0] cap_pc;
    logic [PROBE_W-1:0] cap_ir;
    logic [FLAG_W-1:0]  cap_flags;
    int                 error_cnt = 0;
    int                 fail_tests = 0;
    int                 errs_before;
    int                 edge_total = 0;
    int                 edge_start;
    int                 cycle_cnt = 0;
    logic               prev_tclk = 1'b0;
    logic               line_busy;

    debug_top UUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rx_i           (rx_i),
        .tx_o           (tx_o),
        .pc_i           (pc_i),
        .ir_i           (ir_i),
        .flags_i        (flags_i),
        .target_clk_o   (target_clk_o),
        .target_rst_n_o (target_rst_n_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // count target clock edges seen while its reset is low
    always @(negedge clk) begin
        if (target_rst_n_o === 1'b0 && target_clk_o !== prev_tclk) begin
            edge_total <= edge_total + 1;
        end
        prev_tclk <= target_clk_o;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic set_entry(input int i, input byte_t cmd, input logic [15:0] ack,
                             input logic snap, input logic tclk, input logic trst,
                             input int edges);
        tbl_cmd[i]   = cmd;
        tbl_ack[i]   = ack;
        tbl_snap[i]  = snap;
        tbl_len[i]   = snap ? SNAP_BYTES : REPLY_BYTES;
        tbl_clk[i]   = tclk;
        tbl_rst[i]   = trst;
        tbl_edges[i] = edges;
    endtask

    task automatic change_probes();
        @(posedge clk);
        lcg_state = lcg_next(lcg_state);
        pc_val    = lcg_state;
        lcg_state = lcg_next(lcg_state);
        ir_val    = lcg_state;
        lcg_state = lcg_next(lcg_state);
        flags_val = lcg_state[31:24];
        pc_i    <= pc_val;
        ir_i    <= ir_val;
        flags_i <= flags_val;
    endtask

    // host side of the link, 8N1 lsb first
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_i <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic recv_byte(output byte_t b, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b1;
        b = '0;
        do begin
            @(negedge clk);
            waited++;
        end while (tx_o !== 1'b0 && waited < FRAME_WAIT);
        if (tx_o !== 1'b0) begin
            ok = 1'b0;
            return;
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);   // middle of start bit
        if (tx_o !== 1'b0) begin
            $display("start bit on tx_o did not last half a bit time");
            error_cnt++;
        end
        for (int i = 0; i < BYTE_W; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (tx_o !== 1'b1) begin
            $display("stop bit on tx_o was low");
            error_cnt++;
        end
    endtask

    function automatic byte_t reply_expect(input int t, input int k);
        case (k)
            0:       return tbl_ack[t][15:8];
            1:       return tbl_ack[t][7:0];
            2:       return 8'h0d;   // cr
            default: return 8'h0a;   // lf
        endcase
    endfunction

    // flags, then pc and ir each lsb first
    function automatic byte_t snap_expect(input int k);
        if (k == 0) return cap_flags;
        if (k <= 4) return cap_pc[8*(k-1) +: 8];
        return cap_ir[8*(k-5) +: 8];
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic collect_reply(input int t);
        byte_t got;
        byte_t exp;
        logic  ok;
        for (int k = 0; k < tbl_len[t]; k++) begin
            recv_byte(got, ok);
            if (!ok) begin
                $display("test %0d: reply byte %0d never arrived on tx_o", t, k);
                error_cnt++;
                return;
            end
            exp = tbl_snap[t] ? snap_expect(k) : reply_expect(t, k);
            check_byte($sformatf("tx_o byte %0d", k), got, exp);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_n_i = 1'b0;
        rx_i    = 1'b1;
        pc_i    = '0;
        ir_i    = '0;
        flags_i = '0;

        set_entry(0,  "z", "Cr", 1'b0, 1'b1, 1'b1, 0);
        set_entry(1,  "x", "Cf", 1'b0, 1'b0, 1'b1, 0);
        set_entry(2,  "z", "Cr", 1'b0, 1'b1, 1'b1, 0);
        set_entry(3,  "c", "Ct", 1'b0, 1'b0, 1'b1, 0);   // pulse ends low
        set_entry(4,  "e", "Ra", 1'b0, 1'b0, 1'b0, 0);
        set_entry(5,  "e", "Ra", 1'b0, 1'b0, 1'b1, 0);
        set_entry(6,  "q", "Ok", 1'b0, 1'b0, 1'b1, 0);
        set_entry(7,  "s", 16'h0, 1'b1, 1'b0, 1'b1, 0);
        set_entry(8,  "z", "Cr", 1'b0, 1'b1, 1'b1, 0);
        set_entry(9,  "r", "Rs", 1'b0, 1'b1, 1'b1, RST_HOLD_CYCLES);
        set_entry(10, "e", "Ra", 1'b0, 1'b1, 1'b0, 0);
        set_entry(11, "r", "Rs", 1'b0, 1'b1, 1'b1, RST_HOLD_CYCLES);
        set_entry(12, "s", 16'h0, 1'b1, 1'b1, 1'b1, 0);
        set_entry(13, "q", "Ok", 1'b0, 1'b1, 1'b1, 0);

        repeat (RST_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        // reset state and a quiet line
        errs_before = error_cnt;
        @(negedge clk);
        check_bit("tx_o", tx_o, 1'b1);
        check_bit("target_clk_o", target_clk_o, 1'b0);
        check_bit("target_rst_n_o", target_rst_n_o, 1'b1);
        line_busy = 1'b0;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge clk);
            if (tx_o !== 1'b1) line_busy = 1'b1;
        end
        if (line_busy) begin
            $display("tx_o sent a frame before any command");
            error_cnt++;
        end
        $display("test reset state: %s", (error_cnt == errs_before) ? "ok" : "FAILED");
        if (error_cnt != errs_before) fail_tests++;

        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = error_cnt;
            change_probes();
            cap_pc     = pc_val;
            cap_ir     = ir_val;
            cap_flags  = flags_val;
            edge_start = edge_total;
            fork
                begin
                    send_byte(tbl_cmd[t]);
                    if (tbl_snap[t]) change_probes();   // dump must ignore these
                end
                collect_reply(t);
            join
            @(negedge clk);
            check_bit("target_clk_o", target_clk_o, tbl_clk[t]);
            check_bit("target_rst_n_o", target_rst_n_o, tbl_rst[t]);
            if (edge_total - edge_start != tbl_edges[t]) begin
                $display("test %0d: saw %0d target clock edges in reset, expected %0d",
                         t, edge_total - edge_start, tbl_edges[t]);
                error_cnt++;
            end
            $display("test %0d cmd %c: %s", t, tbl_cmd[t],
                     (error_cnt == errs_before) ? "ok" : "FAILED");
            if (error_cnt != errs_before) fail_tests++;
        end

        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS + 1, fail_tests, error_cnt);
        if (error_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
common/dbg_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/status_snapshot.sv
rtl/cmd_sequencer.sv
rtl/debug_top.sv
dv/tb_debug_top.sv

/* Makefile */
# Verilator build and run for the serial debug controller

VERILATOR ?= verilator
TOP       ?= tb_debug_top
RTL_TOP   ?= debug_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no pass result in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		common/dbg_pkg.sv uart/uart_rx.sv uart/uart_tx.sv \
		rtl/status_snapshot.sv rtl/cmd_sequencer.sv rtl/debug_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
